/* rtl/rv_pkg.sv */
// Shared widths, encodings and pipeline records for the RV32 integer subset core
// Only the R and I views of an instruction word exist; U, B and J immediates are
// rebuilt from the R view's fields in decode
package rv_pkg;

   // -------------------------------------------------------------------------
   // Widths and reset state
   // -------------------------------------------------------------------------
   localparam int XLEN      = 32;                   // Data path width
   localparam int PC_W      = 32;                   // Address width
   localparam int REG_IDX_W = 5;                    // Register index width
   localparam int NUM_GPR   = 2 ** REG_IDX_W;       // Architectural registers
   localparam logic [PC_W-1:0] RESET_PC = '0;       // First fetch address

   // Major opcodes
   localparam logic [6:0] OP_LUI    = 7'b0110111;
   localparam logic [6:0] OP_IMM    = 7'b0010011;
   localparam logic [6:0] OP_REG    = 7'b0110011;
   localparam logic [6:0] OP_BRANCH = 7'b1100011;
   localparam logic [6:0] OP_JAL    = 7'b1101111;
   localparam logic [6:0] OP_SYSTEM = 7'b1110011;

   // Function codes of the supported subset
   localparam logic [2:0]  F3_ADD   = 3'b000;       // ADD, SUB, ADDI
   localparam logic [2:0]  F3_SLT   = 3'b010;
   localparam logic [2:0]  F3_XOR   = 3'b100;
   localparam logic [2:0]  F3_OR    = 3'b110;
   localparam logic [2:0]  F3_AND   = 3'b111;
   localparam logic [2:0]  F3_BEQ   = 3'b000;
   localparam logic [2:0]  F3_BNE   = 3'b001;
   localparam logic [2:0]  F3_PRIV  = 3'b000;       // WFI lives here
   localparam logic [6:0]  F7_BASE  = 7'h00;
   localparam logic [6:0]  F7_SUB   = 7'h20;
   localparam logic [11:0] F12_WFI  = 12'h105;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
   } alu_op_e;

   // -------------------------------------------------------------------------
   // Instruction word views, MSB first
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [6:0]           funct7;
      logic [REG_IDX_W-1:0] rs2;
      logic [REG_IDX_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0]          imm12;
      logic [REG_IDX_W-1:0] rs1;
      logic [2:0]           funct3;
      logic [REG_IDX_W-1:0] rd;
      logic [6:0]           opcode;
   } i_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   // -------------------------------------------------------------------------
   // Stage records
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] pc;
      instr_u          instr;
   } f2d_t;

   typedef struct packed {
      logic                 valid;
      logic [PC_W-1:0]      pc;
      alu_op_e              alu_op;
      logic [REG_IDX_W-1:0] rd;
      logic [REG_IDX_W-1:0] rs1;
      logic [REG_IDX_W-1:0] rs2;
      logic [XLEN-1:0]      rs1_val;
      logic [XLEN-1:0]      rs2_val;
      logic [XLEN-1:0]      imm;
      logic                 use_imm;         // B operand is imm
      logic                 we;              // Writes rd
      logic                 is_br;
      logic                 br_eq;           // BEQ when set, else BNE
      logic                 is_jal;
      logic                 is_wfi;
   } d2e_t;

   typedef struct packed {
      logic                 valid;
      logic [PC_W-1:0]      pc;
      logic [REG_IDX_W-1:0] rd;
      logic [XLEN-1:0]      data;
   } commit_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] target;
   } reload_t;

endpackage

/* rtl/gpr.sv */
// 32 x 32 general purpose registers, two read ports and one write port
// A read of the register being written returns the new value; x0 reads zero
`timescale 1ns/1ps

module gpr
   import rv_pkg::*;
(
   input  logic                 clk_in,
   input  logic                 rst_n,
   input  logic [REG_IDX_W-1:0] rs1_idx,
   input  logic [REG_IDX_W-1:0] rs2_idx,
   output logic [XLEN-1:0]      rs1_val,
   output logic [XLEN-1:0]      rs2_val,
   input  commit_t              wr            // Writeback from execute
);
   logic [XLEN-1:0] regs_q [NUM_GPR];

   // One read port, write-first bypass
   function automatic logic [XLEN-1:0] rd_port(input logic [REG_IDX_W-1:0] idx);
      if (idx == '0)
         return '0;
      if (wr.valid && wr.rd == idx)
         return wr.data;
      return regs_q[idx];
   endfunction

   always_comb
   begin
      rs1_val = rd_port(rs1_idx);
      rs2_val = rd_port(rs2_idx);
   end

   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_GPR; i++)
            regs_q[i] <= '0;
      end
      else if (wr.valid && wr.rd != '0)
         regs_q[wr.rd] <= wr.data;                  // x0 never written
   end

endmodule

/* rtl/fetch.sv */
// Fetch stage, one instruction word per request on a level/ack port
// ic_req and ic_addr hold until ic_ack; a word acked after a reload is discarded
`timescale 1ns/1ps

module fetch
   import rv_pkg::*;
(
   input  logic            clk_in,
   input  logic            rst_n,
   input  logic            halted,       // No new request while set
   input  reload_t         reload,       // Taken branch or jump from execute
   output logic            ic_req,
   output logic [PC_W-1:0] ic_addr,
   input  logic            ic_ack,       // One cycle, ic_data valid with it
   input  logic [XLEN-1:0] ic_data,
   output f2d_t            f2d
);
   logic [PC_W-1:0] pc_q;                // Address of the next request
   logic [PC_W-1:0] addr_q;              // Address of the outstanding request
   logic            req_q;
   logic            drop_q;              // Outstanding word is stale
   logic [PC_W-1:0] next_pc;
   logic            take;                // Acked word goes to decode
   f2d_t            f2d_q;

   assign next_pc = reload.valid ? reload.target : pc_q;
   assign take    = req_q & ic_ack & ~drop_q & ~reload.valid;

   assign ic_req  = req_q;
   assign ic_addr = addr_q;
   assign f2d     = f2d_q;

   // -------------------------------------------------------------------------
   // Request and PC control
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n)
      begin
         req_q  <= 1'b0;
         drop_q <= 1'b0;
         pc_q   <= RESET_PC;
         addr_q <= RESET_PC;
      end
      else if (req_q)
      begin
         if (ic_ack)
         begin
            req_q  <= 1'b0;                                   // Re-raise next cycle
            drop_q <= 1'b0;
            pc_q   <= take ? addr_q + PC_W'(4) : next_pc;
         end
         else if (reload.valid)
         begin
            drop_q <= 1'b1;                                   // Kill the late word
            pc_q   <= reload.target;
         end
      end
      else
      begin
         pc_q <= next_pc;
         if (!halted)
         begin
            req_q  <= 1'b1;
            addr_q <= next_pc;                                // Target wins on reload
         end
      end
   end

   // Fetch to decode register
   always_ff @(posedge clk_in)
   begin
      if (take)
      begin
         f2d_q.pc    <= addr_q;
         f2d_q.instr <= ic_data;
      end
      f2d_q.valid <= take;
      if (!rst_n)
         f2d_q.valid <= 1'b0;
   end

endmodule

/* rtl/decode.sv */
// Decode stage: fields, immediates and register read for the RV32 subset
// Opcodes outside the subset become bubbles and never reach commit
`timescale 1ns/1ps

module decode
   import rv_pkg::*;
(
   input  logic                 clk_in,
   input  logic                 rst_n,
   input  logic                 flush,         // Reload from execute
   input  f2d_t                 f2d,
   output logic [REG_IDX_W-1:0] rs1_idx,
   output logic [REG_IDX_W-1:0] rs2_idx,
   input  logic [XLEN-1:0]      rs1_val,
   input  logic [XLEN-1:0]      rs2_val,
   output d2e_t                 d2e
);
   instr_u          iw;
   logic            known;                     // Opcode is in the subset
   alu_op_e         alu_op;
   logic            use_imm;
   logic            we;
   logic            is_br;
   logic            br_eq;
   logic            is_jal;
   logic            is_wfi;
   logic [XLEN-1:0] imm;
   d2e_t            d2e_q;

   assign iw      = f2d.instr;
   assign rs1_idx = iw.r.rs1;
   assign rs2_idx = iw.r.rs2;
   assign d2e     = d2e_q;

   // -------------------------------------------------------------------------
   // Opcode and function decode
   // -------------------------------------------------------------------------
   always_comb
   begin
      known   = 1'b0;
      alu_op  = ALU_ADD;
      use_imm = 1'b0;
      we      = 1'b0;
      is_br   = 1'b0;
      br_eq   = 1'b0;
      is_jal  = 1'b0;
      is_wfi  = 1'b0;
      imm     = {{20{iw.i.imm12[11]}}, iw.i.imm12};               // I form by default
      case (iw.r.opcode)
         OP_LUI:
         begin
            known   = 1'b1;
            we      = 1'b1;
            use_imm = 1'b1;
            alu_op  = ALU_PASS_B;
            imm     = {iw.r.funct7, iw.r.rs2, iw.r.rs1, iw.r.funct3, 12'h000};
         end
         OP_IMM:
         begin
            known   = iw.i.funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
            we      = 1'b1;
            use_imm = 1'b1;
            case (iw.i.funct3)
               F3_XOR:  alu_op = ALU_XOR;
               F3_OR:   alu_op = ALU_OR;
               F3_AND:  alu_op = ALU_AND;
               default: alu_op = ALU_ADD;
            endcase
         end
         OP_REG:
         begin
            we = 1'b1;
            case (iw.r.funct3)
               F3_ADD:  alu_op = (iw.r.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
               F3_SLT:  alu_op = ALU_SLT;
               F3_XOR:  alu_op = ALU_XOR;
               F3_OR:   alu_op = ALU_OR;
               default: alu_op = ALU_AND;
            endcase
            known = (iw.r.funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND}
                     && iw.r.funct7 == F7_BASE)
                  || (iw.r.funct3 == F3_ADD && iw.r.funct7 == F7_SUB);
         end
         OP_BRANCH:
         begin
            known = iw.r.funct3 inside {F3_BEQ, F3_BNE};
            is_br = 1'b1;
            br_eq = (iw.r.funct3 == F3_BEQ);
            imm   = {{19{iw.r.funct7[6]}}, iw.r.funct7[6], iw.r.rd[0],
                     iw.r.funct7[5:0], iw.r.rd[4:1], 1'b0};
         end
         OP_JAL:
         begin
            known  = 1'b1;
            we     = 1'b1;
            is_jal = 1'b1;
            imm    = {{11{iw.r.funct7[6]}}, iw.r.funct7[6], iw.r.rs1, iw.r.funct3,
                      iw.r.rs2[0], iw.r.funct7[5:0], iw.r.rs2[4:1], 1'b0};
         end
         OP_SYSTEM:
         begin
            known  = (iw.i.imm12 == F12_WFI) && (iw.i.funct3 == F3_PRIV);
            is_wfi = 1'b1;
         end
         default: known = 1'b0;                                   // Passes as no-op
      endcase
   end

   // Decode to execute register, payload loads every cycle
   always_ff @(posedge clk_in)
   begin
      d2e_q.pc      <= f2d.pc;
      d2e_q.alu_op  <= alu_op;
      d2e_q.rd      <= iw.r.rd;
      d2e_q.rs1     <= iw.r.rs1;
      d2e_q.rs2     <= iw.r.rs2;
      d2e_q.rs1_val <= rs1_val;
      d2e_q.rs2_val <= rs2_val;
      d2e_q.imm     <= imm;
      d2e_q.use_imm <= use_imm;
      d2e_q.we      <= we;
      d2e_q.is_br   <= is_br;
      d2e_q.br_eq   <= br_eq;
      d2e_q.is_jal  <= is_jal;
      d2e_q.is_wfi  <= is_wfi;
      d2e_q.valid   <= f2d.valid & known & ~flush;
      if (!rst_n)
         d2e_q.valid <= 1'b0;
   end

endmodule

/* rtl/execute.sv */
// Execute stage with the writeback register that feeds the GPR write port and commit
// Forwarding covers only the instruction one ahead; older results come through the
// write-first GPR read in decode
`timescale 1ns/1ps

module execute
   import rv_pkg::*;
(
   input  logic    clk_in,
   input  logic    rst_n,
   input  d2e_t    d2e,
   output reload_t reload,          // Combinational, flushes fetch and decode
   output logic    wfi_hit,
   output commit_t commit
);
   commit_t         commit_q;
   logic [XLEN-1:0] op_a;           // rs1 after forwarding
   logic [XLEN-1:0] op_b;           // rs2 after forwarding
   logic [XLEN-1:0] alu_b;
   logic [XLEN-1:0] alu_res;
   logic [XLEN-1:0] wb_data;
   logic            equal;
   logic            taken;

   // Writeback result replaces a stale register value
   function automatic logic [XLEN-1:0] fwd(input logic [REG_IDX_W-1:0] idx,
                                           input logic [XLEN-1:0]      reg_val,
                                           input commit_t              wb);
      if (wb.valid && wb.rd == idx && idx != '0)
         return wb.data;
      return reg_val;
   endfunction

   assign op_a  = fwd(d2e.rs1, d2e.rs1_val, commit_q);
   assign op_b  = fwd(d2e.rs2, d2e.rs2_val, commit_q);
   assign alu_b = d2e.use_imm ? d2e.imm : op_b;

   // -------------------------------------------------------------------------
   // ALU
   // -------------------------------------------------------------------------
   always_comb
   begin
      case (d2e.alu_op)
         ALU_SUB:    alu_res = op_a - alu_b;
         ALU_AND:    alu_res = op_a & alu_b;
         ALU_OR:     alu_res = op_a | alu_b;
         ALU_XOR:    alu_res = op_a ^ alu_b;
         ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
         ALU_PASS_B: alu_res = alu_b;                             // LUI
         default:    alu_res = op_a + alu_b;
      endcase
   end

   // JAL links the return address
   assign wb_data = d2e.is_jal ? d2e.pc + PC_W'(4) : alu_res;

   // -------------------------------------------------------------------------
   // Branch resolution and WFI
   // -------------------------------------------------------------------------
   assign equal = (op_a == op_b);
   assign taken = d2e.valid & (d2e.is_jal | (d2e.is_br & (d2e.br_eq == equal)));

   assign reload.valid  = taken;
   assign reload.target = d2e.pc + d2e.imm;                       // B and J are pc relative
   assign wfi_hit       = d2e.valid & d2e.is_wfi;

   // Writeback register, only real writes to x1..x31 commit
   always_ff @(posedge clk_in)
   begin
      commit_q.pc    <= d2e.pc;
      commit_q.rd    <= d2e.rd;
      commit_q.data  <= wb_data;
      commit_q.valid <= d2e.valid & d2e.we & (d2e.rd != '0);
      if (!rst_n)
         commit_q.valid <= 1'b0;
   end

   assign commit = commit_q;

endmodule

/* rtl/rv_core.sv */
// Four stage in-order RV32 subset core: fetch, decode, execute, writeback
// No loads, stores, CSRs or traps; ext_irq only wakes the core from WFI
`timescale 1ns/1ps

module rv_core
   import rv_pkg::*;
(
   input  logic            clk_in,
   input  logic            rst_n,
   input  logic            ext_irq,      // Wake from WFI
   output logic            ic_req,
   output logic [PC_W-1:0] ic_addr,
   input  logic            ic_ack,
   input  logic [XLEN-1:0] ic_data,
   output commit_t         commit        // Retire trace of register writes
);
   f2d_t                 f2d;
   d2e_t                 d2e;
   reload_t              reload;
   logic                 wfi_hit;
   logic                 halted;
   logic [REG_IDX_W-1:0] rs1_idx;
   logic [REG_IDX_W-1:0] rs2_idx;
   logic [XLEN-1:0]      rs1_val;
   logic [XLEN-1:0]      rs2_val;

   // -------------------------------------------------------------------------
   // Pipeline stages
   // -------------------------------------------------------------------------
   fetch u_fetch
   (
      .clk_in(clk_in), .rst_n(rst_n),
      .halted(halted),
      .reload(reload),                                  // Also drops a late word
      .ic_req(ic_req), .ic_addr(ic_addr),
      .ic_ack(ic_ack), .ic_data(ic_data),
      .f2d(f2d)
   );

   decode u_decode
   (
      .clk_in(clk_in), .rst_n(rst_n),
      .flush(reload.valid),                             // Younger instr in decode
      .f2d(f2d),
      .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
      .rs1_val(rs1_val), .rs2_val(rs2_val),
      .d2e(d2e)
   );

   execute u_execute
   (
      .clk_in(clk_in), .rst_n(rst_n),
      .d2e(d2e),
      .reload(reload),
      .wfi_hit(wfi_hit),
      .commit(commit)
   );

   gpr u_gpr
   (
      .clk_in(clk_in), .rst_n(rst_n),
      .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
      .rs1_val(rs1_val), .rs2_val(rs2_val),
      .wr(commit)                                       // Writeback port
   );

   // -------------------------------------------------------------------------
   // Halt on WFI, wake on reset or ext_irq
   // -------------------------------------------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (!rst_n || ext_irq)
         halted <= 1'b0;                                // Clearing wins
      else if (wfi_hit)
         halted <= 1'b1;
   end

endmodule

/* tests/rv_core_sva.sv */
// Assertions bound into rv_core for the instruction port, the commit port and reset state
// Sampled on the rising clock edge; ic_ack is expected to be a single-cycle pulse
`timescale 1ns/1ps

module rv_core_sva
   import rv_pkg::*;
(
   input logic            clk_in,
   input logic            rst_n,
   input logic            ic_req,
   input logic            ic_ack,
   input logic [PC_W-1:0] ic_addr,
   input commit_t         commit
);

   // Request level and address hold until the ack
   req_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
      ic_req && !ic_ack |=> ic_req && $stable(ic_addr))
      else $error("ic_req or ic_addr changed before ic_ack");

   // Writes to x0 never leave the core
   commit_rd_nonzero: assert property (@(posedge clk_in) disable iff (!rst_n)
      commit.valid |-> commit.rd != '0)
      else $error("commit presented with rd x0");

   req_after_reset: assert property (@(posedge clk_in) $rose(rst_n) |-> !ic_req)
      else $error("ic_req high in the cycle after reset release");

endmodule

/* tests/tb_rv_core.sv */
// Testbench for rv_core with a one-word instruction memory that acks after 0 to 3 cycles
// Program, expected commits and the idle time before the wake come from the golden file
// Words past the program read as unknown opcodes and never commit
`timescale 1ns/1ps

module tb_rv_core;
   import rv_pkg::*;

   localparam int GOLD_WORDS = 128;
   localparam int TIMEOUT    = 400;                  // Cycles allowed per wait
   localparam int TAIL       = 30;                   // Window for stray commits at the end

   logic            clk_in;
   logic            rst_n;
   logic            ext_irq;
   logic            ic_req;
   logic [PC_W-1:0] ic_addr;
   logic            ic_ack;
   logic [XLEN-1:0] ic_data;
   commit_t         commit;

   logic [31:0] gold [GOLD_WORDS];
   logic [31:0] lfsr = 32'h982f;                     // Ack delay source
   int          n_prog;
   int          n_commit;
   int          n_pre;                               // Commits before WFI
   int          exp_base;                            // First commit record in gold
   int          idle_cycles;
   int          n_seen   = 0;
   int          errors   = 0;
   int          tests    = 0;
   int          failed   = 0;
   int          err_mark = 0;
   bit          hung     = 1'b0;                     // A wait ran out

   rv_core dut0
   (
      .clk_in(clk_in), .rst_n(rst_n), .ext_irq(ext_irq),
      .ic_req(ic_req), .ic_addr(ic_addr),
      .ic_ack(ic_ack), .ic_data(ic_data),
      .commit(commit)
   );

   bind rv_core rv_core_sva sva0
   (
      .clk_in(clk_in), .rst_n(rst_n),
      .ic_req(ic_req), .ic_ack(ic_ack), .ic_addr(ic_addr),
      .commit(commit)
   );

   initial
   begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;                  // 100 ns period
   end

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic lfsr_bit();
      logic b;
      b    = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
      return b;
   endfunction

   function automatic logic [XLEN-1:0] word_at(input logic [PC_W-1:0] addr);
      int idx;
      idx = int'(addr[31:2]);
      if (idx < n_prog)
         return gold[1 + idx];
      return {addr[31:7] ^ addr[26:2], 7'b0001011};  // custom-0, a no-op in this core
   endfunction

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      if (errors != err_mark || hung)
      begin
         failed++;
         $display("%-28s FAIL", name);
      end
      else
         $display("%-28s pass", name);
      err_mark = errors;
   endtask

   task automatic wait_first_request();
      int cycles;
      cycles = 0;
      while (!ic_req && cycles < TIMEOUT)
      begin
         @(posedge clk_in);
         #1;
         if (!ic_req)
            check("commit.valid before first fetch", 32'(commit.valid), 32'd0);
         cycles++;
      end
      if (!ic_req)
      begin
         $display("Timeout: the core never requested its first instruction");
         hung = 1'b1;
      end
      else
         check("first ic_addr", ic_addr, RESET_PC);
   endtask

   task automatic wait_commits(input int target, input string what);
      int cycles;
      cycles = 0;
      while (n_seen < target && cycles < TIMEOUT)
      begin
         @(posedge clk_in);
         #1;
         cycles++;
      end
      if (n_seen < target)
      begin
         $display("Timeout: %s, only %0d of %0d commits seen", what, n_seen, target);
         hung = 1'b1;
      end
   endtask

   // Normal gaps in ic_req last one cycle, three in a row means halted
   task automatic wait_quiet();
      int cycles;
      int low_run;
      cycles  = 0;
      low_run = 0;
      while (low_run < 3 && cycles < TIMEOUT)
      begin
         @(posedge clk_in);
         #1;
         low_run = ic_req ? 0 : low_run + 1;
         cycles++;
      end
      if (low_run < 3)
      begin
         $display("Timeout: ic_req kept toggling, the core did not halt on WFI");
         hung = 1'b1;
      end
   endtask

   // ------------------------------------------------------------------------
   // Instruction memory, one pending request at a time
   // ------------------------------------------------------------------------
   initial
   begin : imem_model
      int wait_left;
      bit busy;
      ic_ack    = 1'b0;
      ic_data   = '0;
      wait_left = 0;
      busy      = 1'b0;
      forever
      begin
         @(posedge clk_in);
         #1;
         if (ic_ack)
         begin
            ic_ack = 1'b0;                           // Pulse done, DUT drops ic_req
            busy   = 1'b0;
         end
         else if (ic_req)
         begin
            if (!busy)
            begin
               busy      = 1'b1;
               wait_left = lfsr_bit() ? 2 : 0;       // Two bits, 0 to 3 cycles
               if (lfsr_bit())
                  wait_left++;
            end
            if (wait_left == 0)
            begin
               ic_ack  = 1'b1;
               ic_data = word_at(ic_addr);
            end
            else
               wait_left--;
         end
      end
   end

   // Commits are compared in order at mid cycle
   initial
   begin : commit_monitor
      int base;
      forever
      begin
         @(negedge clk_in);
         if (rst_n && commit.valid)
         begin
            if (n_seen >= n_commit)
            begin
               $display("ERR %0t: commit past the golden list, pc %h rd %0d",
                        $time, commit.pc, commit.rd);
               errors++;
            end
            else
            begin
               base = exp_base + 3 * n_seen;
               check($sformatf("commit %0d pc", n_seen), commit.pc, gold[base]);
               check($sformatf("commit %0d rd", n_seen), 32'(commit.rd), gold[base + 1]);
               check($sformatf("commit %0d data", n_seen), commit.data, gold[base + 2]);
            end
            n_seen++;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------
   initial
   begin : main
      int base_seen;
      rst_n   = 1'b0;
      ext_irq = 1'b0;
      $readmemh("tests/rv_core_golden.txt", gold);
      n_prog      = int'(gold[0]);
      n_commit    = int'(gold[n_prog + 1]);
      n_pre       = int'(gold[n_prog + 2]);
      exp_base    = n_prog + 3;
      idle_cycles = int'(gold[exp_base + 3 * n_commit]);

      repeat (8)
      begin
         @(posedge clk_in);
         #1;
         check("ic_req in reset", 32'(ic_req), 32'd0);
         check("commit.valid in reset", 32'(commit.valid), 32'd0);
      end
      rst_n = 1'b1;
      wait_first_request();
      finish_test("reset and first fetch");

      if (!hung)
      begin
         wait_commits(n_pre, "commits before WFI");   // ALU, forwarding, branches, JAL
         finish_test("alu and control flow");
      end

      if (!hung)
      begin
         wait_quiet();
         base_seen = n_seen;
         if (!hung)
         begin
            repeat (idle_cycles)
            begin
               @(posedge clk_in);
               #1;
               check("ic_req while halted", 32'(ic_req), 32'd0);
            end
            check("commits while halted", 32'(n_seen - base_seen), 32'd0);
         end
         finish_test("halt on wfi");
      end

      if (!hung)
      begin
         ext_irq = 1'b1;                             // One cycle wake pulse
         @(posedge clk_in);
         #1;
         ext_irq = 1'b0;
         wait_commits(n_commit, "commits after wake");
         repeat (TAIL) @(posedge clk_in);
         finish_test("wake and remaining commits");
      end

      $display("Summary: %0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0 && !hung)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* rv_core.f */
rtl/rv_pkg.sv
rtl/gpr.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/rv_core.sv
tests/rv_core_sva.sv
tests/tb_rv_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := rv_core.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Something failed
PASS_MSG   := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/rv_core_golden.txt */
// Word 0 program length, then program words from address 0, four per line
// Then commit count and commits before WFI, records as pc rd data, then idle cycles
0000001f
123450b7 67800113 002081b3 fff18213   // 00 lui, addi, add, addi
404182b3 0f01f313 00f36393 7ff3c413   // 10 sub, andi, ori, xori
0081f4b3 0082e533 004545b3 ffb00613   // 20 and, or, xor, addi
005626b3 00c2a733 00208033 00d28663   // 30 slt, slt, add x0, beq taken
11100793 22200793 00e29663 33300813   // 40 skipped, skipped, bne taken, skipped
44400813 00e28463 00c008ef 55500913   // 50 skipped, beq not taken, jal, skipped
66600913 00488993 10500073 00000013   // 60 skipped, addi on link, wfi, nop
01098a13 003a0ab3 0000006f            // 70 addi, add, jal x0 self loop
00000012 00000010
00000000 01 12345000
00000004 02 00000678
00000008 03 12345678
0000000c 04 12345677
00000010 05 00000001
00000014 06 00000070
00000018 07 0000007f
0000001c 08 00000780
00000020 09 00000600
00000024 0a 00000781
00000028 0b 123451f6
0000002c 0c fffffffb
00000030 0d 00000001
00000034 0e 00000000
00000058 11 0000005c
00000064 13 00000060
00000070 14 00000070
00000074 15 123456e8
00000014
